// ==== common/tetris_macros.svh ====
`ifndef TETRIS_MACROS_SVH
`define TETRIS_MACROS_SVH

// playfield size
`define BOARD_ROWS 20
`define BOARD_COLS 10

// column of the pivot cell that new pieces are placed around
`define SPAWN_COL 4

// reset value of the piece sequencer, must not be zero
`define SEQ_SEED 16'hACE1

`endif

// ==== common/tetris_pkg.sv ====
`include "tetris_macros.svh"

package tetris_pkg;

    // piece codes in spawn table order
    typedef enum logic [2:0] {
        piece_line      = 3'd0,
        piece_smashboy  = 3'd1,
        piece_l         = 3'd2,
        piece_reverse_l = 3'd3,
        piece_s         = 3'd4,
        piece_z         = 3'd5,
        piece_tee       = 3'd6
    } piece_t;

    // game controller states
    typedef enum logic [2:0] {
        st_idle  = 3'd0,
        st_spawn = 3'd1,
        st_fall  = 3'd2,
        st_lock  = 3'd3,
        st_clear = 3'd4,
        st_over  = 3'd5
    } game_state_t;

    // row 0 at the top and bit 0 the leftmost column
    typedef logic [`BOARD_ROWS-1:0][`BOARD_COLS-1:0] field_t;

endpackage

// ==== verilog/blockgen.sv ====
`timescale 1ns/1ps
`include "tetris_macros.svh"

module blockgen import tetris_pkg::*; (
    input  piece_t current_state,
    input  logic   enable,
    output field_t display_array
);

    always_comb begin
        display_array = '0;
        if (enable) begin
            case (current_state)
                piece_line: begin // vertical bar four rows tall
                    display_array[0][`SPAWN_COL] = 1'b1;
                    display_array[1][`SPAWN_COL] = 1'b1;
                    display_array[2][`SPAWN_COL] = 1'b1;
                    display_array[3][`SPAWN_COL] = 1'b1;
                end
                piece_smashboy: begin // 2x2 square
                    display_array[0][`SPAWN_COL]   = 1'b1;
                    display_array[0][`SPAWN_COL+1] = 1'b1;
                    display_array[1][`SPAWN_COL]   = 1'b1;
                    display_array[1][`SPAWN_COL+1] = 1'b1;
                end
                piece_l: begin
                    display_array[0][`SPAWN_COL]   = 1'b1;
                    display_array[1][`SPAWN_COL]   = 1'b1;
                    display_array[2][`SPAWN_COL]   = 1'b1;
                    display_array[2][`SPAWN_COL+1] = 1'b1; // foot to the right
                end
                piece_reverse_l: begin
                    display_array[0][`SPAWN_COL+1] = 1'b1;
                    display_array[1][`SPAWN_COL+1] = 1'b1;
                    display_array[2][`SPAWN_COL+1] = 1'b1;
                    display_array[2][`SPAWN_COL]   = 1'b1; // foot to the left
                end
                piece_s: begin
                    display_array[0][`SPAWN_COL+2] = 1'b1;
                    display_array[0][`SPAWN_COL+1] = 1'b1;
                    display_array[1][`SPAWN_COL+1] = 1'b1;
                    display_array[1][`SPAWN_COL]   = 1'b1;
                end
                piece_z: begin
                    display_array[0][`SPAWN_COL]   = 1'b1;
                    display_array[0][`SPAWN_COL+1] = 1'b1;
                    display_array[1][`SPAWN_COL+1] = 1'b1;
                    display_array[1][`SPAWN_COL+2] = 1'b1;
                end
                piece_tee: begin
                    // nose on top, bar below
                    display_array[0][`SPAWN_COL]   = 1'b1;
                    display_array[1][`SPAWN_COL-1] = 1'b1;
                    display_array[1][`SPAWN_COL]   = 1'b1;
                    display_array[1][`SPAWN_COL+1] = 1'b1;
                end
                default: begin
                    display_array = '0; // code 7 has no shape
                end
            endcase
        end
    end

endmodule

// ==== verilog/piece_sequencer.sv ====
`timescale 1ns/1ps
`include "tetris_macros.svh"

module piece_sequencer import tetris_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   advance,
    output piece_t next_piece
);

    localparam logic [15:0] toggle_mask = 16'hB400;

    logic [15:0] lfsr;
    logic [15:0] lfsr_mod; // remainder by 7

    // galois form, shifting right
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= `SEQ_SEED;
        end else if (advance) begin
            if (lfsr[0]) begin
                lfsr <= {1'b0, lfsr[15:1]} ^ toggle_mask;
            end else begin
                lfsr <= {1'b0, lfsr[15:1]};
            end
        end
    end

    assign lfsr_mod   = lfsr % 16'd7;
    assign next_piece = piece_t'(lfsr_mod[2:0]); // always 0..6

endmodule

// ==== board_store/board_store.sv ====
`timescale 1ns/1ps
`include "tetris_macros.svh"

module board_store import tetris_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       merge_en,
    input  logic       clear_en,
    input  field_t     piece_mask,
    output field_t     board,
    output logic [2:0] rows_cleared
);

    field_t     compacted;
    logic [4:0] full_cnt;

    // walk from the floor up and pack every row that is not full
    always_comb begin
        int dst;
        dst       = `BOARD_ROWS - 1;
        compacted = '0;
        full_cnt  = '0;
        for (int r = `BOARD_ROWS - 1; r >= 0; r--) begin
            if (&board[r]) begin
                full_cnt = full_cnt + 5'd1;
            end else begin
                compacted[dst] = board[r];
                dst = dst - 1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            board <= '0;
        end else if (merge_en) begin
            board <= board | piece_mask;
        end else if (clear_en) begin
            board <= compacted; // top rows fill with zeros
        end
    end

    // a single piece spans at most four rows, so three bits suffice
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rows_cleared <= '0;
        end else if (clear_en) begin
            rows_cleared <= full_cnt[2:0];
        end else begin
            rows_cleared <= '0; // only valid one cycle after clear_en
        end
    end

endmodule

// ==== game_fsm/game_fsm.sv ====
`timescale 1ns/1ps
`include "tetris_macros.svh"

module game_fsm import tetris_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic        move_left,
    input  logic        move_right,
    input  logic        move_down,
    input  field_t      board,
    input  field_t      spawn_mask,
    input  piece_t      next_piece,
    input  logic [2:0]  rows_cleared,
    output logic        spawn_en,
    output logic        advance,
    output logic        merge_en,
    output logic        clear_en,
    output field_t      piece_mask,
    output piece_t      current_piece,
    output logic        ready,
    output logic        game_over,
    output logic [15:0] score
);

    game_state_t state, state_next;
    field_t      mask_next;
    piece_t      piece_next;

    field_t left_mask, right_mask, down_mask;
    logic   at_left, at_right, at_floor;
    logic   left_free, right_free, down_free;
    logic   spawn_hit;

    // wall contact and one-cell shifts of the falling mask
    always_comb begin
        at_left  = 1'b0;
        at_right = 1'b0;
        at_floor = |piece_mask[`BOARD_ROWS-1];
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            at_left      = at_left | piece_mask[r][0];
            at_right     = at_right | piece_mask[r][`BOARD_COLS-1];
            left_mask[r] = piece_mask[r] >> 1;  // lower column index
            right_mask[r] = piece_mask[r] << 1;
        end
        down_mask[0] = '0;
        for (int r = 1; r < `BOARD_ROWS; r++) begin
            down_mask[r] = piece_mask[r-1];
        end
    end

    assign left_free  = !at_left && ((left_mask & board) == '0);
    assign right_free = !at_right && ((right_mask & board) == '0);
    assign down_free  = !at_floor && ((down_mask & board) == '0);
    assign spawn_hit  = (spawn_mask & board) != '0;

    always_comb begin
        state_next = state;
        mask_next  = piece_mask;
        piece_next = current_piece;
        case (state)
            st_idle: begin
                if (start) begin
                    state_next = st_spawn;
                    piece_next = next_piece;
                end
            end
            st_spawn: begin
                if (spawn_hit) begin
                    state_next = st_over; // stack reached the spawn cells
                end else begin
                    state_next = st_fall;
                    mask_next  = spawn_mask;
                end
            end
            st_fall: begin
                if (move_left) begin
                    if (left_free) mask_next = left_mask;
                end else if (move_right) begin
                    if (right_free) mask_next = right_mask;
                end else if (move_down) begin
                    if (down_free) begin
                        mask_next = down_mask;
                    end else begin
                        state_next = st_lock;
                    end
                end
            end
            st_lock: begin
                mask_next  = '0; // piece now lives in the board
                state_next = st_clear;
            end
            st_clear: begin
                state_next = st_spawn;
                piece_next = next_piece;
            end
            st_over: begin
                state_next = st_over;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= st_idle;
            piece_mask    <= '0;
            current_piece <= piece_line;
            score         <= '0;
        end else begin
            state         <= state_next;
            piece_mask    <= mask_next;
            current_piece <= piece_next;
            score         <= score + 16'(rows_cleared); // zero outside the spawn cycle
        end
    end

    assign spawn_en  = (state == st_spawn);
    assign advance   = (state == st_spawn); // one step per spawned piece
    assign merge_en  = (state == st_lock);
    assign clear_en  = (state == st_clear);
    assign ready     = (state == st_fall);
    assign game_over = (state == st_over);

endmodule

// ==== verilog/tetris_core.sv ====
`timescale 1ns/1ps

module tetris_core import tetris_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic        move_left,
    input  logic        move_right,
    input  logic        move_down,
    output field_t      playfield,
    output logic [15:0] score,
    output logic        game_over,
    output logic        ready,
    output piece_t      current_piece
);

    field_t     board;
    field_t     spawn_mask;
    field_t     piece_mask;
    piece_t     next_piece;
    logic [2:0] rows_cleared;
    logic       spawn_en;
    logic       advance;
    logic       merge_en;
    logic       clear_en;

    blockgen blockgen_inst (
        .current_state (current_piece),
        .enable        (spawn_en),
        .display_array (spawn_mask)
    );

    piece_sequencer piece_sequencer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .advance    (advance),
        .next_piece (next_piece)
    );

    board_store board_store_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .merge_en     (merge_en),
        .clear_en     (clear_en),
        .piece_mask   (piece_mask),
        .board        (board),
        .rows_cleared (rows_cleared)
    );

    game_fsm game_fsm_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .move_left     (move_left),
        .move_right    (move_right),
        .move_down     (move_down),
        .board         (board),
        .spawn_mask    (spawn_mask),
        .next_piece    (next_piece),
        .rows_cleared  (rows_cleared),
        .spawn_en      (spawn_en),
        .advance       (advance),
        .merge_en      (merge_en),
        .clear_en      (clear_en),
        .piece_mask    (piece_mask),
        .current_piece (current_piece),
        .ready         (ready),
        .game_over     (game_over),
        .score         (score)
    );

    assign playfield = board | piece_mask; // locked cells plus the falling piece

endmodule

// ==== bench/tetris_checker.sv ====
`timescale 1ns/1ps

module tetris_checker import tetris_pkg::*; (
    input logic   clk,
    input logic   rst_n,
    input logic   game_over,
    input logic   ready,
    input logic   move_down,
    input logic   down_free,
    input field_t board,
    input field_t piece_mask
);

    // game over only ends with reset
    over_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        game_over |=> game_over)
        else $error("game_over dropped without reset");

    blocked_down: assert property (@(posedge clk) disable iff (!rst_n)
        (ready && move_down && !down_free) |=> !ready)
        else $error("ready stayed high after a blocked down");

    no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        (board & piece_mask) == '0)
        else $error("falling piece overlaps locked cells");

endmodule

bind tetris_core tetris_checker tetris_checker_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .game_over  (game_over),
    .ready      (ready),
    .move_down  (move_down),
    .down_free  (game_fsm_inst.down_free),
    .board      (board),
    .piece_mask (piece_mask)
);

// ==== bench/tetris_tb.sv ====
`timescale 1ns/1ps
`include "tetris_macros.svh"

module tetris_tb import tetris_pkg::*; ();

    localparam int clk_period     = 10;
    localparam int max_cmds       = 2000;
    localparam int cycles_per_cmd = 10;
    localparam int dir_left       = 0;
    localparam int dir_right      = 1;
    localparam int dir_down       = 2;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        move_left;
    logic        move_right;
    logic        move_down;
    field_t      playfield;
    logic [15:0] score;
    logic        game_over;
    logic        ready;
    piece_t      current_piece;

    // software model of the game
    field_t      m_board;
    field_t      m_mask;
    piece_t      m_piece;
    logic [15:0] m_lfsr;
    logic [15:0] m_score;
    logic        m_over;
    logic        m_started;
    logic [31:0] rng_state;
    int          n_cmds;
    event        check_ev;

    tetris_core tetris_core_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .move_left     (move_left),
        .move_right    (move_right),
        .move_down     (move_down),
        .playfield     (playfield),
        .score         (score),
        .game_over     (game_over),
        .ready         (ready),
        .current_piece (current_piece)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // galois step with toggle mask B400
    function automatic logic [15:0] seq_step(logic [15:0] x);
        return x[0] ? ((x >> 1) ^ 16'hB400) : (x >> 1);
    endfunction

    function automatic piece_t piece_of(logic [15:0] x);
        logic [15:0] rem;
        rem = x % 16'd7;
        return piece_t'(rem[2:0]);
    endfunction

    function automatic field_t spawn_pattern(piece_t p);
        field_t f;
        int c;
        f = '0;
        c = `SPAWN_COL;
        case (p)
            piece_line: begin
                f[0][c] = 1'b1;
                f[1][c] = 1'b1;
                f[2][c] = 1'b1;
                f[3][c] = 1'b1;
            end
            piece_smashboy: begin
                f[0][c +: 2] = 2'b11;
                f[1][c +: 2] = 2'b11;
            end
            piece_l: begin
                f[0][c] = 1'b1;
                f[1][c] = 1'b1;
                f[2][c +: 2] = 2'b11;
            end
            piece_reverse_l: begin
                f[0][c+1] = 1'b1;
                f[1][c+1] = 1'b1;
                f[2][c +: 2] = 2'b11;
            end
            piece_s: begin
                f[0][c+1 +: 2] = 2'b11;
                f[1][c +: 2] = 2'b11;
            end
            piece_z: begin
                f[0][c +: 2] = 2'b11;
                f[1][c+1 +: 2] = 2'b11;
            end
            default: begin // t shape
                f[0][c] = 1'b1;
                f[1][c-1 +: 3] = 3'b111;
            end
        endcase
        return f;
    endfunction

    function automatic field_t shift_field(field_t m, int dir);
        field_t s;
        s = '0;
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            if (dir == dir_left) s[r] = m[r] >> 1;
            else if (dir == dir_right) s[r] = m[r] << 1;
            else if (r > 0) s[r] = m[r-1];
        end
        return s;
    endfunction

    function automatic logic can_move(field_t m, field_t b, int dir);
        logic edge_hit;
        edge_hit = 1'b0;
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            if (dir == dir_left) edge_hit = edge_hit | m[r][0];
            if (dir == dir_right) edge_hit = edge_hit | m[r][`BOARD_COLS-1];
        end
        if (dir == dir_down) edge_hit = |m[`BOARD_ROWS-1];
        return !edge_hit && ((shift_field(m, dir) & b) == '0);
    endfunction

    // full rows removed and everything above drops
    function automatic field_t compact_rows(field_t b, output int cnt);
        field_t res;
        int dst;
        res = '0;
        cnt = 0;
        dst = `BOARD_ROWS - 1;
        for (int r = `BOARD_ROWS - 1; r >= 0; r--) begin
            if (b[r] == '1) begin
                cnt++;
            end else begin
                res[dst] = b[r];
                dst--;
            end
        end
        return res;
    endfunction

    task automatic model_spawn();
        field_t pat;
        m_piece = piece_of(m_lfsr);
        pat = spawn_pattern(m_piece);
        m_lfsr = seq_step(m_lfsr);
        if ((pat & m_board) != '0) begin
            m_over = 1'b1;
            m_mask = '0;
        end else begin
            m_mask = pat;
        end
    endtask

    task automatic model_cmd(int dir);
        int cnt;
        if (can_move(m_mask, m_board, dir)) begin
            m_mask = shift_field(m_mask, dir);
        end else if (dir == dir_down) begin
            m_board = compact_rows(m_board | m_mask, cnt);
            m_mask  = '0;
            m_score = m_score + 16'(cnt);
            model_spawn();
        end
    endtask

    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_field(field_t got, field_t exp, string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_piece(piece_t got, piece_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: current_piece is %s, expected %s",
                     $time, got.name(), exp.name());
            stop_run();
        end
    endtask

    task automatic compare_count(logic [15:0] got, logic [15:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: score is %0d, expected %0d", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    always @(check_ev) begin
        compare_field(playfield, m_board | m_mask, "playfield");
        if (m_started) compare_piece(current_piece, m_piece);
        compare_count(score, m_score);
        compare_flag(game_over, m_over, "game_over");
        compare_flag(ready, m_started && !m_over, "ready");
    end

    task automatic start_game();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        m_started = 1'b1;
        model_spawn();
        while (!ready && !game_over) @(negedge clk);
        -> check_ev;
    endtask

    task automatic run_cmd(int dir);
        logic blocked;
        while (!ready) @(negedge clk);
        blocked = (dir == dir_down) && !can_move(m_mask, m_board, dir_down);
        move_left  = (dir == dir_left);
        move_right = (dir == dir_right);
        move_down  = (dir == dir_down);
        @(negedge clk);
        move_left  = 1'b0;
        move_right = 1'b0;
        move_down  = 1'b0;
        model_cmd(dir);
        if (blocked) begin
            while (!ready && !game_over) @(negedge clk); // lock, clear, spawn
        end
        n_cmds++;
        -> check_ev;
    endtask

    task automatic drop_piece();
        logic more;
        more = 1'b1;
        while (more && !m_over) begin
            more = can_move(m_mask, m_board, dir_down);
            run_cmd(dir_down);
        end
    endtask

    // steer to the column that lets the piece sink deepest
    task automatic place_greedy();
        field_t m;
        logic ok;
        int best_off, best_depth, depth, dir;
        best_off   = 0;
        best_depth = -1;
        for (int off = -9; off <= 9; off++) begin
            m   = m_mask;
            ok  = 1'b1;
            dir = (off < 0) ? dir_left : dir_right;
            for (int k = 0; k < ((off < 0) ? -off : off); k++) begin
                if (can_move(m, m_board, dir)) m = shift_field(m, dir);
                else ok = 1'b0;
            end
            depth = 0;
            while (ok && can_move(m, m_board, dir_down)) begin
                m = shift_field(m, dir_down);
                depth++;
            end
            if (ok && depth > best_depth) begin
                best_depth = depth;
                best_off   = off;
            end
        end
        dir = (best_off < 0) ? dir_left : dir_right;
        for (int k = 0; k < ((best_off < 0) ? -best_off : best_off); k++) begin
            run_cmd(dir);
        end
        drop_piece();
    endtask

    initial begin
        #(max_cmds * cycles_per_cmd * clk_period);
        $display("timeout: the run did not finish in time");
        stop_run();
    end

    initial begin
        logic [2:0] pick;
        clk        = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        move_left  = 1'b0;
        move_right = 1'b0;
        move_down  = 1'b0;
        m_board    = '0;
        m_mask     = '0;
        m_piece    = piece_line;
        m_lfsr     = `SEQ_SEED;
        m_score    = '0;
        m_over     = 1'b0;
        m_started  = 1'b0;
        rng_state  = 32'd43421;
        n_cmds     = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        -> check_ev; // empty field in idle
        @(negedge clk);

        start_game();
        repeat (6) run_cmd(dir_left); // runs into the left wall
        repeat (10) run_cmd(dir_right); // and then into the right wall
        drop_piece();

        // flat stacking so that rows fill up
        for (int i = 0; i < 30 && !m_over; i++) begin
            place_greedy();
        end
        if (m_score == 0) begin
            $display("no row was ever cleared during the stacking phase");
            stop_run();
        end

        while (!m_over && n_cmds < max_cmds - 100) begin
            rng_state = xorshift(rng_state);
            pick = rng_state[2:0];
            if (pick < 3'd5) run_cmd(dir_down);
            else run_cmd(rng_state[3] ? dir_left : dir_right);
        end
        if (!m_over) begin
            $display("random play never reached game over");
            stop_run();
        end

        // every command must now be ignored
        for (int i = 0; i < 30; i++) begin
            rng_state = xorshift(rng_state);
            start      = rng_state[0];
            move_left  = rng_state[1];
            move_right = rng_state[2];
            move_down  = rng_state[3];
            @(negedge clk);
            start      = 1'b0;
            move_left  = 1'b0;
            move_right = 1'b0;
            move_down  = 1'b0;
            -> check_ev;
            @(negedge clk);
        end

        $display("sim passed");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+common
common/tetris_pkg.sv
verilog/blockgen.sv
verilog/piece_sequencer.sv
board_store/board_store.sv
game_fsm/game_fsm.sv
verilog/tetris_core.sv
bench/tetris_checker.sv
bench/tetris_tb.sv

// ==== Bender.yml ====
package:
  name: tetris_core

sources:
  - include_dirs:
      - common
    files:
      - common/tetris_pkg.sv
      - verilog/blockgen.sv
      - verilog/piece_sequencer.sv
      - board_store/board_store.sv
      - game_fsm/game_fsm.sv
      - verilog/tetris_core.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tetris_checker.sv
      - bench/tetris_tb.sv
